//--- common/noc_pkg.sv
`default_nettype none

package noc_pkg;

        localparam int PORT_NUM    = 5;
        localparam int PORT_W      = 3;
        localparam int DATA_W      = 32;
        localparam int VCH_W       = 2;
        localparam int COORD_W     = 2;

        // Flit layout: destination X and Y in the top bits, payload below.
        localparam int DST_X_LSB   = 30;
        localparam int DST_Y_LSB   = 28;

        localparam int QUEUE_DEPTH = 4;
        localparam int QPTR_W      = $clog2(QUEUE_DEPTH);
        localparam int QCNT_W      = $clog2(QUEUE_DEPTH + 1);

        typedef enum logic [PORT_W-1:0] {
                PORT_LOCAL = 3'd0,
                PORT_NORTH = 3'd1,
                PORT_EAST  = 3'd2,
                PORT_SOUTH = 3'd3,
                PORT_WEST  = 3'd4
        } port_e;

        typedef logic [PORT_NUM-1:0] port_vec_t;   // One bit per port.

endpackage

`default_nettype wire

//--- common/xbar_port_if.sv
`default_nettype none

interface xbar_port_if import noc_pkg::*; ();

        logic [DATA_W-1:0]      flit;   // Head flit of the input queue.
        logic                   valid;
        logic [VCH_W-1:0]       vch;
        port_e                  port;   // Output requested by the head flit.
        logic                   req;
        port_vec_t              grt;    // Bit per output, at most one set.

        modport requester (
                output flit,
                output valid,
                output vch,
                output port,
                output req,
                input  grt
        );

        modport switch (
                input  flit,
                input  valid,
                input  vch,
                input  port,
                input  req,
                output grt
        );

endinterface

`default_nettype wire

//--- rtl/input_queue.sv
`default_nettype none

module input_queue import noc_pkg::*; #(
        parameter logic [COORD_W-1:0] ROUTER_X = '0,
        parameter logic [COORD_W-1:0] ROUTER_Y = '0
) (
        input  logic                    clk,
        input  logic                    rst_n,
        input  logic [DATA_W-1:0]       in_data,
        input  logic [VCH_W-1:0]        in_vch,
        input  logic                    in_valid,
        output logic                    in_ready,
        xbar_port_if.requester          xp
);

        logic [DATA_W-1:0]      flit_mem [QUEUE_DEPTH];
        logic [VCH_W-1:0]       vch_mem [QUEUE_DEPTH];
        logic [QPTR_W-1:0]      wr_ptr;
        logic [QPTR_W-1:0]      rd_ptr;
        logic [QCNT_W-1:0]      count;
        logic                   push;
        logic                   pop;
        logic [COORD_W-1:0]     dst_x;
        logic [COORD_W-1:0]     dst_y;
        port_e                  route;

        function automatic logic [QPTR_W-1:0] ptr_inc(input logic [QPTR_W-1:0] p);
                return (p == QPTR_W'(QUEUE_DEPTH - 1)) ? '0 : p + 1'b1;
        endfunction

        assign in_ready = (count != QCNT_W'(QUEUE_DEPTH));
        assign push     = in_valid && in_ready;
        assign pop      = xp.req && xp.grt[xp.port];    // Granted on the requested output.

        always_ff @(posedge clk) begin
                if (!rst_n) begin
                        wr_ptr <= '0;
                        rd_ptr <= '0;
                        count  <= '0;
                end else begin
                        if (push) begin
                                wr_ptr <= ptr_inc(wr_ptr);
                        end
                        if (pop) begin
                                rd_ptr <= ptr_inc(rd_ptr);
                        end
                        count <= count + QCNT_W'(push) - QCNT_W'(pop);
                end
        end

        always_ff @(posedge clk) begin
                if (push) begin
                        flit_mem[wr_ptr] <= in_data;
                        vch_mem[wr_ptr]  <= in_vch;
                end
        end

        assign dst_x = flit_mem[rd_ptr][DST_X_LSB +: COORD_W];
        assign dst_y = flit_mem[rd_ptr][DST_Y_LSB +: COORD_W];

        // XY order: resolve X first, then Y.
        always_comb begin
                if (dst_x > ROUTER_X) begin
                        route = PORT_EAST;
                end else if (dst_x < ROUTER_X) begin
                        route = PORT_WEST;
                end else if (dst_y > ROUTER_Y) begin
                        route = PORT_SOUTH;
                end else if (dst_y < ROUTER_Y) begin
                        route = PORT_NORTH;
                end else begin
                        route = PORT_LOCAL;
                end
        end

        assign xp.flit  = flit_mem[rd_ptr];
        assign xp.vch   = vch_mem[rd_ptr];
        assign xp.valid = (count != '0);
        assign xp.req   = (count != '0);        // Held while a head flit waits.
        assign xp.port  = route;

        a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
                count <= QCNT_W'(QUEUE_DEPTH))
                else $error("input_queue: enqueue into full queue");

        a_grant_on_req: assert property (@(posedge clk) disable iff (!rst_n)
                |xp.grt |-> xp.req && (xp.grt == (port_vec_t'(1) << xp.port)))
                else $error("input_queue: grant without matching request");

endmodule

`default_nettype wire

//--- crossbar/out_arbiter.sv
`default_nettype none

module out_arbiter import noc_pkg::*; (
        input  logic            clk,
        input  logic            rst_n,
        input  port_vec_t       req,
        output port_vec_t       grt,
        output port_vec_t       sel
);

        port_e                  ptr;    // Highest priority input.
        int unsigned            cand;
        int unsigned            winner;
        logic                   found;

        // First requester at or after the pointer, circular order.
        always_comb begin
                grt    = '0;
                found  = 1'b0;
                winner = 0;
                cand   = 0;
                for (int k = 0; k < PORT_NUM; k++) begin
                        cand = (int'(ptr) + k) % PORT_NUM;
                        if (!found && req[cand]) begin
                                grt[cand] = 1'b1;
                                winner    = cand;
                                found     = 1'b1;
                        end
                end
        end

        always_ff @(posedge clk) begin
                if (!rst_n) begin
                        ptr <= PORT_LOCAL;
                        sel <= '0;
                end else begin
                        sel <= grt;     // Matches the cycle the mux register loads.
                        if (found) begin
                                ptr <= port_e'((winner == PORT_NUM - 1) ? 0 : winner + 1);
                        end
                end
        end

        a_grt_onehot: assert property (@(posedge clk) disable iff (!rst_n)
                $onehot0(grt))
                else $error("out_arbiter: more than one grant");

        a_grt_subset: assert property (@(posedge clk) disable iff (!rst_n)
                (grt & ~req) == '0)
                else $error("out_arbiter: grant to idle input");

endmodule

`default_nettype wire

//--- crossbar/out_mux.sv
`default_nettype none

module out_mux import noc_pkg::*; (
        input  logic                    clk,
        input  logic                    rst_n,
        input  logic [DATA_W-1:0]       flit [PORT_NUM],
        input  logic [VCH_W-1:0]        vch [PORT_NUM],
        input  port_vec_t               grt,
        output logic [DATA_W-1:0]       out_data,
        output logic [VCH_W-1:0]        out_vch,
        output logic                    out_valid
);

        logic [DATA_W-1:0]      flit_sel;
        logic [VCH_W-1:0]       vch_sel;

        // AND-OR select, grant is one-hot.
        always_comb begin
                flit_sel = '0;
                vch_sel  = '0;
                for (int i = 0; i < PORT_NUM; i++) begin
                        flit_sel = flit_sel | ({DATA_W{grt[i]}} & flit[i]);
                        vch_sel  = vch_sel | ({VCH_W{grt[i]}} & vch[i]);
                end
        end

        always_ff @(posedge clk) begin
                if (!rst_n) begin
                        out_valid <= 1'b0;
                end else begin
                        out_valid <= |grt;      // Single cycle strobe.
                end
        end

        always_ff @(posedge clk) begin
                if (|grt) begin
                        out_data <= flit_sel;
                        out_vch  <= vch_sel;
                end
        end

        a_sel_onehot: assert property (@(posedge clk) disable iff (!rst_n)
                $onehot0(grt))
                else $error("out_mux: select is not one-hot");

endmodule

`default_nettype wire

//--- crossbar/crossbar.sv
`default_nettype none

module crossbar import noc_pkg::*; (
        input  logic                    clk,
        input  logic                    rst_n,
        xbar_port_if.switch             xp [PORT_NUM],
        output logic [DATA_W-1:0]       out_data [PORT_NUM],
        output logic [VCH_W-1:0]        out_vch [PORT_NUM],
        output logic                    out_valid [PORT_NUM]
);

        logic [DATA_W-1:0]      flit_a [PORT_NUM];
        logic [VCH_W-1:0]       vch_a [PORT_NUM];
        logic                   in_req [PORT_NUM];
        port_e                  in_port [PORT_NUM];
        port_vec_t              req_o [PORT_NUM];       // Indexed by output.
        port_vec_t              grt_o [PORT_NUM];
        port_vec_t              sel_o [PORT_NUM];
        port_vec_t              grt_i [PORT_NUM];       // Indexed by input.

        for (genvar i = 0; i < PORT_NUM; i++) begin : g_in
                assign flit_a[i]  = xp[i].flit;
                assign vch_a[i]   = xp[i].vch;
                assign in_req[i]  = xp[i].req && xp[i].valid;
                assign in_port[i] = xp[i].port;
                assign xp[i].grt  = grt_i[i];
        end

        // Filter requests per output and transpose grants back.
        always_comb begin
                for (int o = 0; o < PORT_NUM; o++) begin
                        for (int i = 0; i < PORT_NUM; i++) begin
                                req_o[o][i] = in_req[i] && (in_port[i] == port_e'(o));
                                grt_i[i][o] = grt_o[o][i];
                        end
                end
        end

        for (genvar o = 0; o < PORT_NUM; o++) begin : g_out
                out_arbiter arb_i (
                        .clk       (clk),
                        .rst_n     (rst_n),
                        .req       (req_o[o]),
                        .grt       (grt_o[o]),
                        .sel       (sel_o[o])
                );

                out_mux mux_i (
                        .clk       (clk),
                        .rst_n     (rst_n),
                        .flit      (flit_a),
                        .vch       (vch_a),
                        .grt       (grt_o[o]),
                        .out_data  (out_data[o]),
                        .out_vch   (out_vch[o]),
                        .out_valid (out_valid[o])
                );

                // Registered flit comes from the input the arbiter picked.
                for (genvar i = 0; i < PORT_NUM; i++) begin : g_sel
                        a_sel_flit: assert property (@(posedge clk) disable iff (!rst_n)
                                sel_o[o][i] |-> out_valid[o]
                                        && out_data[o] == $past(flit_a[i])
                                        && out_vch[o] == $past(vch_a[i]))
                                else $error("crossbar: output flit not from granted input");
                end
        end

endmodule

`default_nettype wire

//--- rtl/router_switch.sv
`default_nettype none

module router_switch import noc_pkg::*; #(
        parameter logic [COORD_W-1:0] ROUTER_X = '0,
        parameter logic [COORD_W-1:0] ROUTER_Y = '0
) (
        input  logic                    clk,
        input  logic                    rst_n,

        input  logic [DATA_W-1:0]       in_data_0,
        input  logic [VCH_W-1:0]        in_vch_0,
        input  logic                    in_valid_0,
        output logic                    in_ready_0,
        output logic [DATA_W-1:0]       out_data_0,
        output logic [VCH_W-1:0]        out_vch_0,
        output logic                    out_valid_0,

        input  logic [DATA_W-1:0]       in_data_1,
        input  logic [VCH_W-1:0]        in_vch_1,
        input  logic                    in_valid_1,
        output logic                    in_ready_1,
        output logic [DATA_W-1:0]       out_data_1,
        output logic [VCH_W-1:0]        out_vch_1,
        output logic                    out_valid_1,

        input  logic [DATA_W-1:0]       in_data_2,
        input  logic [VCH_W-1:0]        in_vch_2,
        input  logic                    in_valid_2,
        output logic                    in_ready_2,
        output logic [DATA_W-1:0]       out_data_2,
        output logic [VCH_W-1:0]        out_vch_2,
        output logic                    out_valid_2,

        input  logic [DATA_W-1:0]       in_data_3,
        input  logic [VCH_W-1:0]        in_vch_3,
        input  logic                    in_valid_3,
        output logic                    in_ready_3,
        output logic [DATA_W-1:0]       out_data_3,
        output logic [VCH_W-1:0]        out_vch_3,
        output logic                    out_valid_3,

        input  logic [DATA_W-1:0]       in_data_4,
        input  logic [VCH_W-1:0]        in_vch_4,
        input  logic                    in_valid_4,
        output logic                    in_ready_4,
        output logic [DATA_W-1:0]       out_data_4,
        output logic [VCH_W-1:0]        out_vch_4,
        output logic                    out_valid_4
);

        logic [DATA_W-1:0]      out_data_a [PORT_NUM];
        logic [VCH_W-1:0]       out_vch_a [PORT_NUM];
        logic                   out_valid_a [PORT_NUM];

        xbar_port_if xp [PORT_NUM] ();         // One link per input queue.

        input_queue #(.ROUTER_X(ROUTER_X), .ROUTER_Y(ROUTER_Y)) iq_0 (
                .clk(clk), .rst_n(rst_n),
                .in_data  (in_data_0),
                .in_vch   (in_vch_0),
                .in_valid (in_valid_0),
                .in_ready (in_ready_0),
                .xp       (xp[0])
        );

        input_queue #(.ROUTER_X(ROUTER_X), .ROUTER_Y(ROUTER_Y)) iq_1 (
                .clk(clk), .rst_n(rst_n),
                .in_data  (in_data_1),
                .in_vch   (in_vch_1),
                .in_valid (in_valid_1),
                .in_ready (in_ready_1),
                .xp       (xp[1])
        );

        input_queue #(.ROUTER_X(ROUTER_X), .ROUTER_Y(ROUTER_Y)) iq_2 (
                .clk(clk), .rst_n(rst_n),
                .in_data  (in_data_2),
                .in_vch   (in_vch_2),
                .in_valid (in_valid_2),
                .in_ready (in_ready_2),
                .xp       (xp[2])
        );

        input_queue #(.ROUTER_X(ROUTER_X), .ROUTER_Y(ROUTER_Y)) iq_3 (
                .clk(clk), .rst_n(rst_n),
                .in_data  (in_data_3),
                .in_vch   (in_vch_3),
                .in_valid (in_valid_3),
                .in_ready (in_ready_3),
                .xp       (xp[3])
        );

        input_queue #(.ROUTER_X(ROUTER_X), .ROUTER_Y(ROUTER_Y)) iq_4 (
                .clk(clk), .rst_n(rst_n),
                .in_data  (in_data_4),
                .in_vch   (in_vch_4),
                .in_valid (in_valid_4),
                .in_ready (in_ready_4),
                .xp       (xp[4])
        );

        crossbar xbar_i (
                .clk       (clk),
                .rst_n     (rst_n),
                .xp        (xp),
                .out_data  (out_data_a),
                .out_vch   (out_vch_a),
                .out_valid (out_valid_a)
        );

        assign out_data_0  = out_data_a[PORT_LOCAL];
        assign out_vch_0   = out_vch_a[PORT_LOCAL];
        assign out_valid_0 = out_valid_a[PORT_LOCAL];
        assign out_data_1  = out_data_a[PORT_NORTH];
        assign out_vch_1   = out_vch_a[PORT_NORTH];
        assign out_valid_1 = out_valid_a[PORT_NORTH];
        assign out_data_2  = out_data_a[PORT_EAST];
        assign out_vch_2   = out_vch_a[PORT_EAST];
        assign out_valid_2 = out_valid_a[PORT_EAST];
        assign out_data_3  = out_data_a[PORT_SOUTH];
        assign out_vch_3   = out_vch_a[PORT_SOUTH];
        assign out_valid_3 = out_valid_a[PORT_SOUTH];
        assign out_data_4  = out_data_a[PORT_WEST];
        assign out_vch_4   = out_vch_a[PORT_WEST];
        assign out_valid_4 = out_valid_a[PORT_WEST];

endmodule

`default_nettype wire

//--- dv/clk_gen.sv
`default_nettype none

module clk_gen #(
        parameter int PERIOD       = 4,
        parameter int RESET_CYCLES = 3
) (
        output logic clk,
        output logic rst_n
);

        initial begin
                clk = 1'b0;
                forever #(PERIOD / 2) clk = ~clk;
        end

        initial begin
                rst_n = 1'b0;
                repeat (RESET_CYCLES) @(posedge clk);
                #1 rst_n = 1'b1;        // Released off the edge.
        end

endmodule

`default_nettype wire

//--- dv/tb_router_switch.sv
`default_nettype none

module tb_router_switch import noc_pkg::*; ();

        localparam logic [COORD_W-1:0] RX = 2'd1;
        localparam logic [COORD_W-1:0] RY = 2'd1;
        localparam int          SRC_LSB        = 25;   // Payload holds source, then sequence.
        localparam logic [11:0] SEQ_BAD        = 12'hfff;
        localparam int          LONE_FLITS     = PORT_NUM * 16;
        localparam int          RAND_CYCLES    = 150;
        localparam int          CONT_CYCLES    = 60;
        localparam int          MAX_FLITS      = LONE_FLITS + (RAND_CYCLES + CONT_CYCLES) * PORT_NUM;
        localparam int          TIMEOUT_CYCLES = MAX_FLITS * PORT_NUM * 8 + 100;
        localparam int          DRAIN_LIMIT    = 64;
        localparam int          CONT_PORT      = PORT_EAST;    // Target (3, 1) lies east.

        wire                            clk;
        wire                            rst_n;
        logic [DATA_W-1:0]              in_data [PORT_NUM];
        logic [VCH_W-1:0]               in_vch [PORT_NUM];
        logic [PORT_NUM-1:0]            in_valid;
        wire  [PORT_NUM-1:0]            in_ready;
        wire  [DATA_W-1:0]              out_data [PORT_NUM];
        wire  [VCH_W-1:0]               out_vch [PORT_NUM];
        wire  [PORT_NUM-1:0]            out_valid;

        logic [VCH_W+DATA_W-1:0]        exp_q [PORT_NUM*PORT_NUM][$];  // Output major, source minor.
        int                             exp_cyc [PORT_NUM*PORT_NUM][$];
        int                             acc [PORT_NUM];
        int                             dlv [PORT_NUM];
        int                             seq [PORT_NUM];
        int                             hist [PORT_NUM];
        int                             hist_n;
        int                             cyc = 0;
        logic [PORT_NUM-1:0]            data_ok;
        logic [PORT_NUM-1:0]            lat_ok;
        logic [PORT_NUM-1:0]            rdy_ok;
        logic                           fair_ok;
        logic                           lone_mode;
        logic                           busy_win;
        logic [DATA_W-1:0]              seen_data [PORT_NUM];
        int                             err_value;
        int                             err_lost;

        clk_gen clk_gen_i (.clk(clk), .rst_n(rst_n));

        router_switch #(.ROUTER_X(RX), .ROUTER_Y(RY)) dut_i (
                .clk(clk), .rst_n(rst_n),
                .in_data_0(in_data[0]), .in_vch_0(in_vch[0]),
                .in_valid_0(in_valid[0]), .in_ready_0(in_ready[0]),
                .out_data_0(out_data[0]), .out_vch_0(out_vch[0]), .out_valid_0(out_valid[0]),
                .in_data_1(in_data[1]), .in_vch_1(in_vch[1]),
                .in_valid_1(in_valid[1]), .in_ready_1(in_ready[1]),
                .out_data_1(out_data[1]), .out_vch_1(out_vch[1]), .out_valid_1(out_valid[1]),
                .in_data_2(in_data[2]), .in_vch_2(in_vch[2]),
                .in_valid_2(in_valid[2]), .in_ready_2(in_ready[2]),
                .out_data_2(out_data[2]), .out_vch_2(out_vch[2]), .out_valid_2(out_valid[2]),
                .in_data_3(in_data[3]), .in_vch_3(in_vch[3]),
                .in_valid_3(in_valid[3]), .in_ready_3(in_ready[3]),
                .out_data_3(out_data[3]), .out_vch_3(out_vch[3]), .out_valid_3(out_valid[3]),
                .in_data_4(in_data[4]), .in_vch_4(in_vch[4]),
                .in_valid_4(in_valid[4]), .in_ready_4(in_ready[4]),
                .out_data_4(out_data[4]), .out_vch_4(out_vch[4]), .out_valid_4(out_valid[4])
        );

        function automatic int xy_port(input logic [DATA_W-1:0] f);
                logic [COORD_W-1:0] dx;
                logic [COORD_W-1:0] dy;
                dx = f[DST_X_LSB +: COORD_W];
                dy = f[DST_Y_LSB +: COORD_W];
                if (dx != RX) begin
                        return (dx > RX) ? int'(PORT_EAST) : int'(PORT_WEST);
                end
                if (dy != RY) begin
                        return (dy > RY) ? int'(PORT_SOUTH) : int'(PORT_NORTH);
                end
                return int'(PORT_LOCAL);
        endfunction

        function automatic int pending();
                int n;
                n = 0;
                for (int i = 0; i < PORT_NUM; i++) begin
                        n += acc[i] - dlv[i];
                end
                return n;
        endfunction

        task automatic step();
                @(posedge clk);
                #1;
        endtask

        task automatic offer(input int s, input int dx, input int dy);
                logic [11:0] tag;
                tag = in_ready[s] ? 12'(seq[s]) : SEQ_BAD;      // A refused flit must never leave.
                if (in_ready[s]) begin
                        seq[s]++;
                end
                in_data[s]  = {2'(dx), 2'(dy), 3'(s), tag, 13'($urandom)};
                in_vch[s]   = VCH_W'($urandom);
                in_valid[s] = 1'b1;
        endtask

        task automatic wait_drained();
                int n;
                n = 0;
                while (pending() != 0 && n < DRAIN_LIMIT) begin
                        step();
                        n++;
                end
                a_no_loss: assert (pending() == 0) else begin
                        err_lost += pending();
                        $display("Lost flits: %0d accepted flits never left the router", pending());
                end
        endtask

        task automatic finish_run(input logic timed_out);
                $display("Errors: %0d wrong values, %0d lost flits, timeout %0d",
                        err_value, err_lost, timed_out);
                if (err_value == 0 && err_lost == 0 && !timed_out) begin
                        $display("All checks passed");
                end else begin
                        $display("Checks failed");
                end
                $finish;
        endtask

        always @(posedge clk) begin
                cyc <= cyc + 1;
        end

        // Outputs and offers are both stable at the falling edge.
        always @(negedge clk) begin : monitor
                int src;
                int idx;
                int o;
                logic [VCH_W+DATA_W-1:0] head;
                if (rst_n) begin
                        for (int p = 0; p < PORT_NUM; p++) begin
                                data_ok[p]   = !out_valid[p];
                                lat_ok[p]    = 1'b1;
                                seen_data[p] = out_data[p];
                                src = int'(out_data[p][SRC_LSB +: 3]);
                                idx = p * PORT_NUM + src;
                                if (out_valid[p] && src < PORT_NUM && exp_q[idx].size() != 0) begin
                                        head = exp_q[idx].pop_front();
                                        data_ok[p] = (head == {out_vch[p], out_data[p]});
                                        lat_ok[p]  = (cyc - exp_cyc[idx].pop_front() == 2);
                                        dlv[src]++;
                                        if (busy_win && p == CONT_PORT) begin
                                                hist[hist_n % PORT_NUM] = src;
                                                hist_n++;
                                        end
                                end
                        end
                        fair_ok = 1'b1;
                        for (int a = 0; a < PORT_NUM; a++) begin
                                for (int b = a + 1; b < PORT_NUM; b++) begin
                                        if (hist_n >= PORT_NUM && hist[a] == hist[b]) begin
                                                fair_ok = 1'b0;
                                        end
                                end
                        end
                        for (int i = 0; i < PORT_NUM; i++) begin
                                rdy_ok[i] = (in_ready[i] == (acc[i] - dlv[i] < QUEUE_DEPTH));
                                if (in_valid[i] && in_ready[i]) begin
                                        o = xy_port(in_data[i]);
                                        exp_q[o * PORT_NUM + i].push_back({in_vch[i], in_data[i]});
                                        exp_cyc[o * PORT_NUM + i].push_back(cyc);
                                        acc[i]++;
                                end
                        end
                end
        end

        a_reset_state: assert property (@(posedge clk)
                $rose(rst_n) |-> out_valid == '0 && &in_ready)
                else begin
                        err_value++;
                        $display("ERR %0t: ports not idle after reset", $time);
                end

        for (genvar p = 0; p < PORT_NUM; p++) begin : g_chk
                a_flit: assert property (@(posedge clk) disable iff (!rst_n)
                        out_valid[p] |-> data_ok[p])
                        else begin
                                err_value++;
                                $display("ERR %0t: output %0d gave unexpected flit %h",
                                        $time, p, seen_data[p]);
                        end

                a_latency: assert property (@(posedge clk) disable iff (!rst_n)
                        lone_mode && out_valid[p] |-> lat_ok[p])
                        else begin
                                err_value++;
                                $display("ERR %0t: output %0d latency is not 2 cycles", $time, p);
                        end

                a_ready: assert property (@(posedge clk) disable iff (!rst_n) rdy_ok[p])
                        else begin
                                err_value++;
                                $display("ERR %0t: in_ready %0d disagrees with queue fill", $time, p);
                        end
        end

        a_busy: assert property (@(posedge clk) disable iff (!rst_n)
                busy_win |-> out_valid[CONT_PORT])
                else begin
                        err_value++;
                        $display("ERR %0t: contended output idle for a cycle", $time);
                end

        a_fair: assert property (@(posedge clk) disable iff (!rst_n)
                busy_win && out_valid[CONT_PORT] |-> fair_ok)
                else begin
                        err_value++;
                        $display("ERR %0t: last five flits not from five sources", $time);
                end

        initial begin : watchdog
                repeat (TIMEOUT_CYCLES) @(posedge clk);
                $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
                finish_run(1'b1);
        end

        initial begin : stimulus
                void'($urandom(32'hc85f_198a));
                in_valid = '0;
                for (int i = 0; i < PORT_NUM; i++) begin
                        in_data[i] = '0;
                        in_vch[i]  = '0;
                        acc[i]     = 0;
                        dlv[i]     = 0;
                        seq[i]     = 0;
                        hist[i]    = 0;
                end
                hist_n    = 0;
                data_ok   = '1;
                lat_ok    = '1;
                rdy_ok    = '1;
                fair_ok   = 1'b1;
                lone_mode = 1'b0;
                busy_win  = 1'b0;
                err_value = 0;
                err_lost  = 0;
                @(posedge rst_n);
                step();

                lone_mode = 1'b1;       // One flit in flight at a time.
                for (int s = 0; s < PORT_NUM; s++) begin
                        for (int d = 0; d < 16; d++) begin
                                offer(s, d % 4, d / 4);
                                step();
                                in_valid[s] = 1'b0;
                                wait_drained();
                                step();
                        end
                end
                lone_mode = 1'b0;

                repeat (RAND_CYCLES) begin
                        for (int s = 0; s < PORT_NUM; s++) begin
                                if ($urandom % 2) begin
                                        offer(s, $urandom % 4, $urandom % 4);
                                end else begin
                                        in_valid[s] = 1'b0;
                                end
                        end
                        step();
                end
                in_valid = '0;
                wait_drained();

                // Every input aims at one output until all queues back up.
                for (int c = 0; c < CONT_CYCLES; c++) begin
                        for (int s = 0; s < PORT_NUM; s++) begin
                                offer(s, 3, 1);
                        end
                        busy_win = (c >= 10 && c < CONT_CYCLES - 2);
                        step();
                end
                busy_win = 1'b0;
                in_valid = '0;
                wait_drained();
                finish_run(1'b0);
        end

endmodule

`default_nettype wire

//--- verilog.f
common/noc_pkg.sv
common/xbar_port_if.sv
rtl/input_queue.sv
crossbar/out_arbiter.sv
crossbar/out_mux.sv
crossbar/crossbar.sv
rtl/router_switch.sv
dv/clk_gen.sv
dv/tb_router_switch.sv

//--- Bender.yml
package:
  name: router_switch

sources:
  - common/noc_pkg.sv
  - common/xbar_port_if.sv
  - rtl/input_queue.sv
  - crossbar/out_arbiter.sv
  - crossbar/out_mux.sv
  - crossbar/crossbar.sv
  - rtl/router_switch.sv
  - target: test
    files:
      - dv/clk_gen.sv
      - dv/tb_router_switch.sv
